// ==== design/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath width in bits
`define MIPS_XLEN 32

// Instruction memory, in 32-bit words
`define MIPS_IMEM_DEPTH 256
`define MIPS_IMEM_AW    8

// Data memory, in 32-bit words
`define MIPS_DMEM_DEPTH 64
`define MIPS_DMEM_AW    6

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // R-type function codes
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_form_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_form_t;

  // Both forms share opcode, rs and rt
  typedef union packed {
    r_form_t r;
    i_form_t i;
  } instr_t;

endpackage

// ==== design/pipe_pkg.sv ====
`include "mips_cfg.svh"

package pipe_pkg;
  import isa_pkg::*;

  typedef logic [`MIPS_XLEN-1:0] word_t;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;     // Immediate as second ALU operand
    logic    reg_dst;     // Write rd rather than rt
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    branch;
  } ctrl_t;

  // IF/ID payload
  typedef struct packed {
    logic   valid;
    word_t  pc_plus4;
    instr_t instr;
  } if_id_t;

  // ID/EX payload
  typedef struct packed {
    logic       valid;
    ctrl_t      ctrl;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    word_t      rs_data;
    word_t      rt_data;
    word_t      imm;       // Sign extended
    word_t      br_target;
  } id_ex_t;

  // EX/MEM payload
  typedef struct packed {
    logic       valid;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic [4:0] dest;
    word_t      alu_result;
    word_t      store_data;
  } ex_mem_t;

  // MEM/WB payload, register write port and core output
  typedef struct packed {
    logic       valid;     // Only for writes to a nonzero register
    logic [4:0] dest;
    word_t      data;
  } wb_t;

endpackage

// ==== design/pipe_reg.sv ====
module pipe_reg #(
  parameter type PAYLOAD_T = logic
) (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_hold,
  input  logic     i_flush,
  input  PAYLOAD_T i_d,
  output PAYLOAD_T o_q
);

  // Flush beats hold, so a redirect squashes a stalled entry
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_q <= '0;
    end else if (i_flush) begin
      o_q <= '0;             // Bubble with valid low
    end else if (!i_hold) begin
      o_q <= i_d;
    end
  end

endmodule

// ==== design/fetch_stage.sv ====
`include "mips_cfg.svh"

module fetch_stage
  import pipe_pkg::*;
(
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_stall,
  input  logic                     i_redirect,
  input  word_t                    i_redirect_pc,
  input  logic                     i_imem_we,
  input  logic [`MIPS_IMEM_AW-1:0] i_imem_addr,
  input  word_t                    i_imem_data,
  output if_id_t                   o_if_id
);

  word_t pc;
  word_t pc_plus4;
  word_t pc_next;
  word_t imem [`MIPS_IMEM_DEPTH];

  assign pc_plus4 = pc + word_t'(4);

  always_comb begin
    if (i_redirect) begin
      pc_next = i_redirect_pc;    // Mispredict correction
    end else if (i_stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // Load port, used by the testbench while reset is held
  always_ff @(posedge clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_data;
    end
  end

  always_comb begin
    o_if_id.valid    = i_rst_n;   // Low while reset is held
    o_if_id.pc_plus4 = pc_plus4;
    o_if_id.instr    = imem[pc[`MIPS_IMEM_AW+1:2]];
  end

endmodule

// ==== design/reg_file.sv ====
module reg_file
  import pipe_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic [4:0] i_rs,
  input  logic [4:0] i_rt,
  input  wb_t        i_wb,
  output word_t      o_rs_data,
  output word_t      o_rt_data
);

  word_t regs [1:31];   // r0 is not stored

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid && i_wb.dest != 5'd0) begin
      regs[i_wb.dest] <= i_wb.data;
    end
  end

  // Write-through covers the WB to ID distance
  always_comb begin
    if (i_rs == 5'd0)                            o_rs_data = '0;
    else if (i_wb.valid && i_wb.dest == i_rs)    o_rs_data = i_wb.data;
    else                                         o_rs_data = regs[i_rs];
    if (i_rt == 5'd0)                            o_rt_data = '0;
    else if (i_wb.valid && i_wb.dest == i_rt)    o_rt_data = i_wb.data;
    else                                         o_rt_data = regs[i_rt];
  end

endmodule

// ==== design/decode_stage.sv ====
`include "mips_cfg.svh"

module decode_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic   clk,
  input  logic   i_rst_n,
  input  if_id_t i_if_id,
  input  wb_t    i_wb,
  input  id_ex_t i_id_ex_q,
  output id_ex_t o_id_ex,
  output logic   o_stall
);

  instr_t instr;
  ctrl_t  ctrl;
  logic   uses_rt;         // rt is a source operand
  logic   load_in_ex;
  word_t  rs_data;
  word_t  rt_data;
  word_t  imm_ext;

  assign instr = i_if_id.instr;

  // Register file sits beside the decode logic
  reg_file u_reg_file (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_rs      (instr.r.rs),
    .i_rt      (instr.r.rt),
    .i_wb      (i_wb),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  always_comb begin
    ctrl    = '0;
    uses_rt = 1'b0;
    case (instr.r.opcode)
      OP_RTYPE: begin
        uses_rt        = 1'b1;
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (instr.r.funct)
          FN_ADD:  ctrl.alu_op = ALU_ADD;
          FN_SUB:  ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.reg_write = 1'b0;  // funct 0 is the no-op
        endcase
      end
      OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_src    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OP_SW: begin
        uses_rt        = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      OP_BEQ: begin
        uses_rt     = 1'b1;
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;   // Zero result means equal
      end
      default: ;                 // Unknown opcodes run as no-ops
    endcase
  end

  assign imm_ext = {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};

  // Load in EX whose result the decoding instruction needs
  assign load_in_ex = i_id_ex_q.valid && i_id_ex_q.ctrl.mem_read && (i_id_ex_q.rt != 5'd0);
  assign o_stall    = i_if_id.valid && load_in_ex &&
                      ((i_id_ex_q.rt == instr.r.rs) ||
                       (uses_rt && i_id_ex_q.rt == instr.r.rt));

  always_comb begin
    o_id_ex.valid     = i_if_id.valid;
    o_id_ex.ctrl      = ctrl;
    o_id_ex.rs        = instr.r.rs;
    o_id_ex.rt        = instr.r.rt;
    o_id_ex.rd        = instr.r.rd;
    o_id_ex.rs_data   = rs_data;
    o_id_ex.rt_data   = rt_data;
    o_id_ex.imm       = imm_ext;
    o_id_ex.br_target = i_if_id.pc_plus4 + (imm_ext << 2);
  end

endmodule

// ==== design/execute_stage.sv ====
module execute_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  id_ex_t  i_id_ex,
  input  ex_mem_t i_ex_mem_q,
  input  wb_t     i_mem_wb_q,
  output ex_mem_t o_ex_mem,
  output logic    o_redirect,
  output word_t   o_redirect_pc
);

  word_t fwd_a;
  word_t fwd_b;
  word_t op_b;
  word_t alu_y;

  // EX/MEM first, then MEM/WB, then the value read in decode
  function automatic word_t forward(input logic [4:0] src, input word_t reg_val,
                                    input ex_mem_t ex_mem, input wb_t wb);
    if (src != 5'd0 && ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
        ex_mem.dest == src) begin
      return ex_mem.alu_result;
    end else if (wb.valid && wb.dest == src) begin
      return wb.data;
    end else begin
      return reg_val;
    end
  endfunction

  assign fwd_a = forward(i_id_ex.rs, i_id_ex.rs_data, i_ex_mem_q, i_mem_wb_q);
  assign fwd_b = forward(i_id_ex.rt, i_id_ex.rt_data, i_ex_mem_q, i_mem_wb_q);
  assign op_b  = i_id_ex.ctrl.alu_src ? i_id_ex.imm : fwd_b;

  always_comb begin
    case (i_id_ex.ctrl.alu_op)
      ALU_ADD: alu_y = fwd_a + op_b;
      ALU_SUB: alu_y = fwd_a - op_b;
      ALU_AND: alu_y = fwd_a & op_b;
      ALU_OR:  alu_y = fwd_a | op_b;
      ALU_SLT: alu_y = word_t'($signed(fwd_a) < $signed(op_b));
      default: alu_y = '0;
    endcase
  end

  // Predict not taken, so any taken beq is a mispredict
  assign o_redirect    = i_id_ex.valid && i_id_ex.ctrl.branch && (alu_y == '0);
  assign o_redirect_pc = i_id_ex.br_target;

  always_comb begin
    o_ex_mem.valid      = i_id_ex.valid;
    o_ex_mem.reg_write  = i_id_ex.valid && i_id_ex.ctrl.reg_write;
    o_ex_mem.mem_read   = i_id_ex.valid && i_id_ex.ctrl.mem_read;
    o_ex_mem.mem_write  = i_id_ex.valid && i_id_ex.ctrl.mem_write;
    o_ex_mem.mem_to_reg = i_id_ex.ctrl.mem_to_reg;
    o_ex_mem.dest       = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;
    o_ex_mem.alu_result = alu_y;
    o_ex_mem.store_data = fwd_b;   // Forwarded rt for sw
  end

endmodule

// ==== design/mem_stage.sv ====
`include "mips_cfg.svh"

module mem_stage
  import pipe_pkg::*;
(
  input  logic    clk,
  input  ex_mem_t i_ex_mem,
  output wb_t     o_wb
);

  word_t                    dmem [`MIPS_DMEM_DEPTH];
  logic [`MIPS_DMEM_AW-1:0] addr;
  word_t                    rdata;

  assign addr  = i_ex_mem.alu_result[`MIPS_DMEM_AW+1:2];   // Word address
  assign rdata = dmem[addr];

  always_ff @(posedge clk) begin
    if (i_ex_mem.valid && i_ex_mem.mem_write) begin
      dmem[addr] <= i_ex_mem.store_data;
    end
  end

  always_comb begin
    o_wb.valid = i_ex_mem.valid && i_ex_mem.reg_write && (i_ex_mem.dest != 5'd0);
    o_wb.dest  = i_ex_mem.dest;
    o_wb.data  = i_ex_mem.mem_to_reg ? rdata : i_ex_mem.alu_result;
  end

endmodule

// ==== design/mips_core.sv ====
`include "mips_cfg.svh"

module mips_core
  import pipe_pkg::*;
(
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_imem_we,
  input  logic [`MIPS_IMEM_AW-1:0] i_imem_addr,
  input  word_t                    i_imem_data,
  output wb_t                      o_wb
);

  if_id_t  if_id_d,  if_id_q;
  id_ex_t  id_ex_d,  id_ex_q;
  ex_mem_t ex_mem_d, ex_mem_q;
  wb_t     mem_wb_d, mem_wb_q;
  logic    stall;
  logic    redirect;
  word_t   redirect_pc;

  fetch_stage u_fetch (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_stall       (stall),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .i_imem_we     (i_imem_we),
    .i_imem_addr   (i_imem_addr),
    .i_imem_data   (i_imem_data),
    .o_if_id       (if_id_d)
  );

  // Held on load-use, squashed on mispredict
  pipe_reg #(.PAYLOAD_T(if_id_t)) u_if_id (
    .clk (clk), .i_rst_n (i_rst_n), .i_hold (stall), .i_flush (redirect),
    .i_d (if_id_d), .o_q (if_id_q)
  );

  decode_stage u_decode (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_if_id   (if_id_q),
    .i_wb      (mem_wb_q),
    .i_id_ex_q (id_ex_q),
    .o_id_ex   (id_ex_d),
    .o_stall   (stall)
  );

  pipe_reg #(.PAYLOAD_T(id_ex_t)) u_id_ex (
    .clk (clk), .i_rst_n (i_rst_n), .i_hold (1'b0), .i_flush (stall | redirect),
    .i_d (id_ex_d), .o_q (id_ex_q)
  );

  execute_stage u_execute (
    .i_id_ex       (id_ex_q),
    .i_ex_mem_q    (ex_mem_q),
    .i_mem_wb_q    (mem_wb_q),
    .o_ex_mem      (ex_mem_d),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  pipe_reg #(.PAYLOAD_T(ex_mem_t)) u_ex_mem (
    .clk (clk), .i_rst_n (i_rst_n), .i_hold (1'b0), .i_flush (1'b0),
    .i_d (ex_mem_d), .o_q (ex_mem_q)
  );

  mem_stage u_mem (
    .clk      (clk),
    .i_ex_mem (ex_mem_q),
    .o_wb     (mem_wb_d)
  );

  pipe_reg #(.PAYLOAD_T(wb_t)) u_mem_wb (
    .clk (clk), .i_rst_n (i_rst_n), .i_hold (1'b0), .i_flush (1'b0),
    .i_d (mem_wb_d), .o_q (mem_wb_q)
  );

  assign o_wb = mem_wb_q;   // Retired register writes in program order

endmodule

// ==== tb/tb_mips_core.sv ====
`include "mips_cfg.svh"

module tb_mips_core
  import isa_pkg::*;
  import pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMEM_AW   = `MIPS_IMEM_AW;
  localparam int DMEM_AW   = `MIPS_DMEM_AW;
  localparam int NUM_TESTS = 5;
  localparam int PAD_WORDS = 16;   // No-ops after each program
  localparam int DRAIN     = 6;    // Quiet cycles that must show no extra retirement

  logic               clk = 1'b0;
  logic               i_rst_n;
  logic               i_imem_we;
  logic [IMEM_AW-1:0] i_imem_addr;
  word_t              i_imem_data;
  wb_t                o_wb;

  word_t       prog_words [$];   // All programs back to back
  int          prog_start [NUM_TESTS];
  int          prog_len   [NUM_TESTS];
  string       test_name  [NUM_TESTS];
  wb_t         exp_q [$];        // Expected register writes in program order
  logic [31:0] lfsr_state = 32'd50;
  int          watchdog_cycles = 0;

  mips_core i_mips_core (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_imem_we   (i_imem_we),
    .i_imem_addr (i_imem_addr),
    .i_imem_data (i_imem_data),
    .o_wb        (o_wb)
  );

  always #5 clk = ~clk;

  function automatic word_t enc_r(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                  logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_i(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int k = 0; k < n; k++) begin
      b          = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // ISA interpreter, pushes every write to a nonzero register
  function automatic void run_model(int start, int len);
    word_t       regs [32];
    word_t       dmem [`MIPS_DMEM_DEPTH];
    word_t       w, a, b, imm, addr, res;
    logic [4:0]  dst;
    logic        wr;
    wb_t         e;
    int          pc, nxt, steps;
    foreach (regs[k]) regs[k] = '0;
    foreach (dmem[k]) dmem[k] = '0;
    pc    = 0;
    steps = 0;
    while (pc >= 0 && pc < len && steps < 10000) begin
      w    = prog_words[start + pc];
      a    = regs[w[25:21]];
      b    = regs[w[20:16]];
      imm  = {{16{w[15]}}, w[15:0]};
      addr = a + imm;
      wr   = 1'b0;
      dst  = w[20:16];    // rt unless R-type
      res  = '0;
      nxt  = pc + 1;
      case (w[31:26])
        OP_RTYPE: begin
          dst = w[15:11];
          wr  = 1'b1;
          case (w[5:0])
            FN_ADD:  res = a + b;
            FN_SUB:  res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: wr = 1'b0;
          endcase
        end
        OP_ADDI: begin
          res = addr;
          wr  = 1'b1;
        end
        OP_LW: begin
          res = dmem[addr[DMEM_AW+1:2]];
          wr  = 1'b1;
        end
        OP_SW:   dmem[addr[DMEM_AW+1:2]] = b;
        OP_BEQ:  if (a == b) nxt = pc + 1 + int'($signed(w[15:0]));
        default: ;
      endcase
      if (wr && dst != 5'd0) begin
        regs[dst] = res;
        e.valid   = 1'b1;
        e.dest    = dst;
        e.data    = res;
        exp_q.push_back(e);
      end
      pc = nxt;
      steps++;
    end
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  task automatic gen_random(int count);
    int         kind;
    logic [4:0] rd, rs, rt;
    logic [5:0] fn;
    // Prologue seeds r1..r8 and stores them to words 0..7
    for (int k = 1; k <= 8; k++) begin
      prog_words.push_back(enc_i(OP_ADDI, 5'(k), 5'd0, 16'(rand_bits(16))));
    end
    for (int k = 0; k < 8; k++) begin
      prog_words.push_back(enc_i(OP_SW, 5'(k + 1), 5'd0, 16'(k * 4)));
    end
    for (int n = 16; n < count; n++) begin
      kind = int'(rand_bits(3));
      rd   = 5'(rand_bits(5));
      rs   = 5'(rand_bits(5));
      rt   = 5'(rand_bits(5));
      case (kind)
        2, 3: prog_words.push_back(enc_i(OP_ADDI, rt, rs, 16'(rand_bits(16))));
        4:    prog_words.push_back(enc_i(OP_LW, rt, 5'd0, 16'(rand_bits(3) * 4)));
        5:    prog_words.push_back(enc_i(OP_SW, rt, 5'd0, 16'(rand_bits(3) * 4)));
        6:    prog_words.push_back(enc_i(OP_BEQ, rt, rs, 16'(rand_bits(2) % 3 + 1)));
        default: begin
          case (rand_bits(3) % 5)
            0:       fn = FN_ADD;
            1:       fn = FN_SUB;
            2:       fn = FN_AND;
            3:       fn = FN_OR;
            default: fn = FN_SLT;
          endcase
          prog_words.push_back(enc_r(fn, rd, rs, rt));
        end
      endcase
    end
  endtask

  task automatic build_programs();
    prog_start[0] = prog_words.size();
    test_name[0]  = "reset and first retirement";
    prog_words.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd7));
    prog_words.push_back(enc_r(FN_ADD, 5'd2, 5'd1, 5'd1));
    prog_words.push_back(32'h0000_0000);                   // No-op
    prog_words.push_back(enc_i(OP_ADDI, 5'd3, 5'd0, 16'hffff));
    prog_len[1 - 1] = prog_words.size() - prog_start[0];

    prog_start[1] = prog_words.size();
    test_name[1]  = "dependent ALU chain";
    prog_words.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd5));
    prog_words.push_back(enc_i(OP_ADDI, 5'd2, 5'd1, 16'hfff4));   // -7
    prog_words.push_back(enc_r(FN_SUB, 5'd3, 5'd2, 5'd1));
    prog_words.push_back(enc_r(FN_SLT, 5'd4, 5'd3, 5'd2));        // Both negative
    prog_words.push_back(enc_r(FN_SLT, 5'd5, 5'd2, 5'd3));
    prog_words.push_back(enc_r(FN_AND, 5'd6, 5'd3, 5'd1));
    prog_words.push_back(enc_r(FN_OR, 5'd7, 5'd6, 5'd2));
    prog_words.push_back(enc_r(FN_ADD, 5'd0, 5'd7, 5'd1));        // Write to r0
    prog_words.push_back(enc_r(FN_ADD, 5'd8, 5'd0, 5'd7));
    prog_words.push_back(enc_i(OP_ADDI, 5'd9, 5'd8, 16'd1));
    prog_len[1] = prog_words.size() - prog_start[1];

    prog_start[2] = prog_words.size();
    test_name[2]  = "store, load and load-use";
    prog_words.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'h0040));
    prog_words.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'h1234));
    prog_words.push_back(enc_i(OP_SW, 5'd2, 5'd1, 16'd8));
    prog_words.push_back(enc_i(OP_LW, 5'd3, 5'd1, 16'd8));
    prog_words.push_back(enc_r(FN_ADD, 5'd4, 5'd3, 5'd3));        // Uses the load at once
    prog_words.push_back(enc_i(OP_LW, 5'd5, 5'd1, 16'd8));
    prog_words.push_back(enc_i(OP_SW, 5'd5, 5'd1, 16'd12));
    prog_words.push_back(enc_i(OP_LW, 5'd6, 5'd1, 16'd12));
    prog_words.push_back(enc_i(OP_ADDI, 5'd7, 5'd6, 16'd1));
    prog_len[2] = prog_words.size() - prog_start[2];

    prog_start[3] = prog_words.size();
    test_name[3]  = "branches";
    prog_words.push_back(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd3));
    prog_words.push_back(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd3));
    prog_words.push_back(enc_i(OP_BEQ, 5'd2, 5'd1, 16'd2));       // Taken
    prog_words.push_back(enc_i(OP_ADDI, 5'd10, 5'd0, 16'h0111));
    prog_words.push_back(enc_i(OP_ADDI, 5'd11, 5'd0, 16'h0222));
    prog_words.push_back(enc_i(OP_ADDI, 5'd12, 5'd0, 16'h0333));
    prog_words.push_back(enc_i(OP_BEQ, 5'd0, 5'd1, 16'd1));       // Not taken
    prog_words.push_back(enc_i(OP_ADDI, 5'd13, 5'd0, 16'h0444));
    prog_words.push_back(enc_i(OP_ADDI, 5'd14, 5'd0, 16'h0555));
    prog_words.push_back(enc_i(OP_ADDI, 5'd15, 5'd0, 16'h0333));
    prog_words.push_back(enc_i(OP_BEQ, 5'd12, 5'd15, 16'd1));     // Taken, forwarded rs
    prog_words.push_back(enc_i(OP_ADDI, 5'd16, 5'd0, 16'h0666));
    prog_words.push_back(enc_i(OP_ADDI, 5'd17, 5'd0, 16'h0777));
    prog_len[3] = prog_words.size() - prog_start[3];

    prog_start[4] = prog_words.size();
    test_name[4]  = "random program";
    gen_random(200);
    prog_len[4] = prog_words.size() - prog_start[4];
  endtask

  // Reset stays low while the program and its no-op tail load, at least 10 cycles
  task automatic load_program(int t);
    int words;
    words = prog_len[t] + PAD_WORDS;
    @(posedge clk);
    #1 i_rst_n = 1'b0;
    for (int n = 0; n < ((words > 10) ? words : 10); n++) begin
      i_imem_we   = (n < words);
      i_imem_addr = IMEM_AW'(n);
      i_imem_data = (n < prog_len[t]) ? prog_words[prog_start[t] + n] : 32'h0;
      @(posedge clk);
      #1;
    end
    i_imem_we = 1'b0;
    i_rst_n   = 1'b1;
  endtask

  // Three cycles per instruction covers a stall or a squashed pair on each
  task automatic wait_retired(int t);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < prog_len[t] * 3 + 20) begin
      @(posedge clk);
      cycles++;
    end
    repeat (DRAIN) @(posedge clk);
    if (exp_q.size() != 0) begin
      fail_run($sformatf("Test %0d (%s) ended with %0d expected register writes not retired",
                         t, test_name[t], exp_q.size()));
    end
    $display("Test %0d (%s) done", t, test_name[t]);
  endtask

  // Compare process, sampled mid-cycle
  always @(negedge clk) begin
    wb_t e;
    if (!i_rst_n) begin
      if (o_wb.valid) fail_run("A register write retired while reset was asserted");
    end else if (o_wb.valid) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("Unexpected retirement to r%0d", o_wb.dest));
      end else begin
        e = exp_q.pop_front();
        check("o_wb.dest", 32'(o_wb.dest), 32'(e.dest));
        check("o_wb.data", o_wb.data, e.data);
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    fail_run($sformatf("Timeout after %0d cycles with %0d writes pending",
                       watchdog_cycles, exp_q.size()));
  end

  initial begin
    int   total;
    int   edges;
    logic seen;
    i_rst_n     = 1'b0;
    i_imem_we   = 1'b0;
    i_imem_addr = '0;
    i_imem_data = '0;
    build_programs();
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) total += prog_len[t] + PAD_WORDS;
    watchdog_cycles = total * 3 + 100;   // Load, run and drain of every test

    // First instruction leaves o_wb on the fourth edge after release
    run_model(prog_start[0], prog_len[0]);
    load_program(0);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < 10) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      seen = o_wb.valid;
    end
    check("first retirement edge", 32'(edges), 32'd4);
    wait_retired(0);

    for (int t = 1; t < NUM_TESTS; t++) begin
      run_model(prog_start[t], prog_len[t]);
      load_program(t);
      wait_retired(t);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/mips_core.sv
tb/tb_mips_core.sv

// ==== Makefile ====
# Verilator build and run of the MIPS pipeline testbench
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
